//--- build.f
source/soc_ctrl_regmap_pkg.sv
source/soc_ctrl_timer_pkg.sv
source/rto_channel.sv
source/rto_status.sv
source/soc_watchdog.sv
source/apb_soc_ctrl.sv
source/soc_ctrl_top.sv
tb/soc_ctrl_chk.sv
tb/tb_soc_ctrl.sv

//--- Bender.yml
package:
  name: soc_ctrl

sources:
  # Packages first, then leaf blocks and the top level
  - source/soc_ctrl_regmap_pkg.sv
  - source/soc_ctrl_timer_pkg.sv
  - source/rto_channel.sv
  - source/rto_status.sv
  - source/soc_watchdog.sv
  - source/apb_soc_ctrl.sv
  - source/soc_ctrl_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - tb/soc_ctrl_chk.sv
      - tb/tb_soc_ctrl.sv

//--- tb/tb_soc_ctrl.sv
`timescale 1ns/1ps

module tb_soc_ctrl
  import soc_ctrl_regmap_pkg::*;
();

  localparam int unsigned N_IO           = 64;
  localparam int unsigned NB_CORES       = 4;
  localparam int unsigned NB_CLUSTERS    = 1;
  localparam int unsigned NB_MASTER      = 4;
  localparam int unsigned JTAG_REG_SIZE  = 8;
  localparam int unsigned TIMEOUT_CYCLES = 4000;  // Tests need a few hundred cycles
  localparam logic [31:0] LFSR_SEED      = 32'h2928;
  localparam logic [31:0] BOOT_ADDR      = 32'h1C00_8080;

  logic                             HCLK;
  logic                             HRESETn;
  logic [11:0]                      paddr_i;
  logic [31:0]                      pwdata_i;
  logic                             pwrite_i;
  logic                             psel_i;
  logic                             penable_i;
  logic [31:0]                      prdata_o;
  logic                             pready_o;
  logic                             pslverr_o;
  logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg_o;
  logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux_o;
  logic [31:0]                      fc_bootaddr_o;
  logic                             fc_fetchen_o;
  logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_i;
  logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_o;
  logic                             bootsel_i;
  logic                             dmactive_i;
  logic                             ref_clk_rising_i;
  logic                             stoptimer_i;
  logic                             wd_expired_o;
  logic [NB_MASTER-1:0]             start_rto_i;
  logic                             rto_o;
  logic                             soft_reset_o;

  logic [31:0] lfsr_state;
  int          cycle_count;
  int          soft_reset_seen;

  soc_ctrl_top #(
    .N_IO          (N_IO),
    .NB_CORES      (NB_CORES),
    .NB_CLUSTERS   (NB_CLUSTERS),
    .NB_MASTER     (NB_MASTER),
    .JTAG_REG_SIZE (JTAG_REG_SIZE)
  ) u_dut (
    .HCLK, .HRESETn,
    .paddr_i, .pwdata_i, .pwrite_i, .psel_i, .penable_i,
    .prdata_o, .pready_o, .pslverr_o,
    .pad_cfg_o, .pad_mux_o,
    .fc_bootaddr_o, .fc_fetchen_o,
    .soc_jtag_reg_i, .soc_jtag_reg_o,
    .bootsel_i, .dmactive_i,
    .ref_clk_rising_i, .stoptimer_i, .wd_expired_o,
    .start_rto_i, .rto_o, .soft_reset_o
  );

  bind soc_ctrl_top soc_ctrl_chk #(.NB_MASTER(NB_MASTER)) u_chk (
    .HCLK, .HRESETn,
    .pready_i      (pready_o),
    .pslverr_i     (pslverr_o),
    .soft_reset_i  (soft_reset_o),
    .rto_i         (rto_o),
    .rto_sticky_i  (rto_sticky)
  );

  initial HCLK = 1'b0;
  always #50 HCLK = ~HCLK;  // 100 ns period

  always @(posedge HCLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  always @(posedge HCLK) begin
    if (u_dut.u_chk.assert_fail_count != 0) begin
      fail_run("A bound assertion failed");
    end
  end

  always @(posedge HCLK) begin
    if (soft_reset_o) soft_reset_seen++;  // Counts high cycles of the pulse
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t ns: %s is 0x%08h, expected 0x%08h",
                         $time, name, got, exp));
    end
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic wait_cycle();
    @(posedge HCLK);
    #1;
  endtask

  // Setup phase, then access phase held until pready_o
  task automatic apb_access(input logic [11:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    wait_cycle();
    paddr_i   = addr;
    pwdata_i  = wdata;
    pwrite_i  = write;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    wait_cycle();
    penable_i = 1'b1;
    do wait_cycle(); while (!pready_o);
    rdata     = prdata_o;
    err       = pslverr_o;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
    check_eq($sformatf("pslverr_o on write 0x%03h", addr), err, 0);
  endtask

  task automatic expect_reg(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b0, '0, rdata, err);
    check_eq($sformatf("pslverr_o on read 0x%03h", addr), err, 0);
    check_eq(name, rdata, exp);
  endtask

  function automatic logic [11:0] window_addr(input int unsigned idx);
    return PAD_WINDOW_BASE + 12'(idx * 4);
  endfunction

  // Indirect word: cfg 29:24, mux 17:16, pad 7:0
  function automatic logic [31:0] wcfg_word(input logic [5:0] pad, input logic [5:0] cfg,
                                            input logic [1:0] mux);
    return {2'b00, cfg, 6'h00, mux, 8'h00, 2'b00, pad};
  endfunction

  // Window word: cfg 13:8, mux 1:0
  function automatic logic [31:0] direct_word(input logic [5:0] cfg, input logic [1:0] mux);
    return {18'h0, cfg, 6'h00, mux};
  endfunction

  task automatic ref_ticks(input int n);
    repeat (n) begin
      wait_cycle();
      ref_clk_rising_i = 1'b1;
      wait_cycle();
      ref_clk_rising_i = 1'b0;
    end
  endtask

  task automatic wait_rto(input int limit, output int cycles);
    cycles = 0;
    while (!rto_o) begin
      wait_cycle();
      cycles++;
      if (cycles > limit) fail_run("rto_o never rose while a master was held waiting");
    end
  endtask

  task automatic check_pads_reset();
    for (int i = 0; i < N_IO; i++) begin
      check_eq($sformatf("pad_cfg_o[%0d]", i), 32'(pad_cfg_o[i]), (32'd1 << NBIT_PADCFG) - 1);
      check_eq($sformatf("pad_mux_o[%0d]", i), 32'(pad_mux_o[i]), 0);
    end
  endtask

  task automatic test_reset_identity();
    check_eq("pready_o", pready_o, 0);
    check_eq("pslverr_o", pslverr_o, 0);
    check_eq("soft_reset_o", soft_reset_o, 0);
    check_eq("rto_o", rto_o, 0);
    check_eq("wd_expired_o", wd_expired_o, 0);
    expect_reg("info", REG_INFO, (NB_CORES << 16) | NB_CLUSTERS);
    check_eq("fc_bootaddr_o", fc_bootaddr_o, BOOTADDR_RESET);
    check_eq("fc_fetchen_o", fc_fetchen_o, 1);
    check_pads_reset();
  endtask

  task automatic test_plain_regs();
    write_reg(REG_FCBOOT, BOOT_ADDR);
    expect_reg("fcboot", REG_FCBOOT, BOOT_ADDR);
    check_eq("fc_bootaddr_o", fc_bootaddr_o, BOOT_ADDR);
    write_reg(REG_FCFETCH, 32'h0);
    expect_reg("fcfetch", REG_FCFETCH, 32'h0);
    check_eq("fc_fetchen_o", fc_fetchen_o, 0);
    write_reg(REG_FCFETCH, 32'h1);
    check_eq("fc_fetchen_o", fc_fetchen_o, 1);
    write_reg(REG_JTAGREG, 32'hA5);
    soc_jtag_reg_i = 8'h3C;
    repeat (2) wait_cycle();  // Two-stage synchronizer
    expect_reg("jtagreg", REG_JTAGREG, 32'h0000_3CA5);
    check_eq("soc_jtag_reg_o", soc_jtag_reg_o, 32'hA5);
    bootsel_i  = 1'b0;
    dmactive_i = 1'b1;
    expect_reg("bootsel", REG_BOOTSEL, 32'h8000_0001);  // Captured dmactive 0, bootsel 1
  endtask

  task automatic test_pads();
    logic [31:0] pad_a, cfg_a, mux_a;
    logic [31:0] pad_b, cfg_b, mux_b;
    logic [31:0] idx, rdata;
    logic        err;
    take_bits(6, pad_a);
    take_bits(6, cfg_a);
    take_bits(2, mux_a);
    write_reg(REG_WCFGFUN, wcfg_word(pad_a[5:0], cfg_a[5:0], mux_a[1:0]));
    expect_reg("pad window", window_addr(pad_a), direct_word(cfg_a[5:0], mux_a[1:0]));
    check_eq("pad_cfg_o after indirect write", 32'(pad_cfg_o[pad_a[5:0]]), cfg_a);
    check_eq("pad_mux_o after indirect write", 32'(pad_mux_o[pad_a[5:0]]), mux_a);
    take_bits(6, pad_b);
    if (pad_b[5:0] == pad_a[5:0]) pad_b ^= 32'h1;
    take_bits(6, cfg_b);
    take_bits(2, mux_b);
    write_reg(window_addr(pad_b), direct_word(cfg_b[5:0], mux_b[1:0]));
    // Window read also selects the pad
    expect_reg("pad window of first pad", window_addr(pad_a),
               direct_word(cfg_a[5:0], mux_a[1:0]));
    write_reg(REG_RCFGFUN, {26'h0, pad_b[5:0]});  // Select pad for readback
    expect_reg("rcfgfun", REG_RCFGFUN, wcfg_word(pad_b[5:0], cfg_b[5:0], mux_b[1:0]));
    check_eq("pad_cfg_o after window write", 32'(pad_cfg_o[pad_b[5:0]]), cfg_b);
    check_eq("pad_mux_o after window write", 32'(pad_mux_o[pad_b[5:0]]), mux_b);
    check_eq("pad_cfg_o of first pad", 32'(pad_cfg_o[pad_a[5:0]]), cfg_a);
    take_bits(6, idx);
    apb_access(window_addr(N_IO + idx), 1'b0, '0, rdata, err);
    check_eq("prdata_o beyond N_IO", rdata, BAD_PAD_DATA);
    apb_access(12'h0F0, 1'b0, '0, rdata, err);
    check_eq("pslverr_o on unmapped read", err, 1);
    check_eq("prdata_o on unmapped read", rdata, BAD_ADDR_DATA);
  endtask

  task automatic test_watchdog();
    int n;
    write_reg(REG_WD_COUNT, 32'd5);
    write_reg(REG_WD_CONTROL, 32'h8000_0000);
    expect_reg("wd control after start", REG_WD_CONTROL, 32'h8000_0005);
    ref_ticks(4);
    wait_cycle();
    check_eq("wd_expired_o before last tick", wd_expired_o, 0);
    ref_ticks(1);
    n = 0;
    while (!wd_expired_o) begin
      wait_cycle();
      n++;
      if (n > 4) fail_run("wd_expired_o did not rise after the count reached zero");
    end
    expect_reg("wd count at expiry", REG_WD_COUNT, 32'd0);
    write_reg(REG_WD_CONTROL, {16'h0, WD_KICK_KEY});
    expect_reg("wd control after kick", REG_WD_CONTROL, 32'h8000_0005);
    check_eq("wd_expired_o after kick", wd_expired_o, 0);
    write_reg(REG_WD_COUNT, 32'd100);  // Ignored while enabled
    ref_ticks(2);
    write_reg(REG_WD_CONTROL, {16'h0, WD_KICK_KEY});
    expect_reg("wd control after late load", REG_WD_CONTROL, 32'h8000_0005);
    stoptimer_i = 1'b1;
    ref_ticks(3);
    expect_reg("wd count while stopped", REG_WD_COUNT, 32'd5);
    stoptimer_i = 1'b0;
    ref_ticks(1);
    expect_reg("wd count after restart", REG_WD_COUNT, 32'd4);
  endtask

  task automatic test_timeout();
    logic [31:0] m, other, reload;
    int          cycles;
    take_bits(2, m);
    other = m ^ 32'h1;
    write_reg(REG_RTO_COUNT, 32'h20);
    reload = 32'h2F;  // 0x20 with the low nibble forced to ones
    expect_reg("rto reload", REG_RTO_COUNT, reload);
    start_rto_i[m[1:0]] = 1'b1;
    wait_rto(reload + 4, cycles);
    check_eq("rto_o latency in cycles", cycles, reload + 1);
    start_rto_i = '0;
    expect_reg("rto sticky", REG_RTO_PERIPHERAL, 32'd1 << m[1:0]);
    start_rto_i[other[1:0]] = 1'b1;
    repeat (5) begin
      wait_cycle();
      check_eq("rto_o during short start", rto_o, 0);
    end
    start_rto_i = '0;
    wait_cycle();
    check_eq("rto_o after short start", rto_o, 0);
    expect_reg("rto sticky after short start", REG_RTO_PERIPHERAL, 32'd1 << m[1:0]);
    write_reg(REG_RTO_PERIPHERAL, 32'h0);
    expect_reg("rto sticky after clear", REG_RTO_PERIPHERAL, 32'h0);
  endtask

  task automatic test_soft_reset();
    logic [31:0] pad, m;
    int          cycles;
    take_bits(6, pad);
    take_bits(2, m);
    write_reg(window_addr(pad), direct_word(6'h15, 2'h2));
    check_eq("pad_cfg_o before soft reset", 32'(pad_cfg_o[pad[5:0]]), 32'h15);
    start_rto_i[m[1:0]] = 1'b1;
    wait_rto(60, cycles);
    start_rto_i = '0;
    expect_reg("rto sticky before soft reset", REG_RTO_PERIPHERAL, 32'd1 << m[1:0]);
    write_reg(REG_RTO_COUNT, 32'h100);
    expect_reg("rto reload before soft reset", REG_RTO_COUNT, 32'h10F);
    check_eq("soft_reset_o pulses before", soft_reset_seen, 0);
    write_reg(REG_SOFT_RESET, 32'h1);
    wait_cycle();
    check_eq("soft_reset_o pulses", soft_reset_seen, 1);
    check_pads_reset();
    expect_reg("rto reload after soft reset", REG_RTO_COUNT, 32'(RTO_RELOAD_RESET));
    expect_reg("rto sticky after soft reset", REG_RTO_PERIPHERAL, 32'h0);
    expect_reg("fcboot after soft reset", REG_FCBOOT, BOOT_ADDR);
    check_eq("fc_bootaddr_o after soft reset", fc_bootaddr_o, BOOT_ADDR);
  endtask

  initial begin
    HRESETn          = 1'b0;
    paddr_i          = '0;
    pwdata_i         = '0;
    pwrite_i         = 1'b0;
    psel_i           = 1'b0;
    penable_i        = 1'b0;
    soc_jtag_reg_i   = '0;
    bootsel_i        = 1'b1;  // Boot pins as seen at reset
    dmactive_i       = 1'b0;
    ref_clk_rising_i = 1'b0;
    stoptimer_i      = 1'b0;
    start_rto_i      = '0;
    lfsr_state       = LFSR_SEED;
    cycle_count      = 0;
    soft_reset_seen  = 0;
    repeat (8) @(posedge HCLK);
    #1 HRESETn = 1'b1;
    test_reset_identity();
    test_plain_regs();
    test_pads();
    test_watchdog();
    test_timeout();
    test_soft_reset();
    if (u_dut.u_chk.assert_fail_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_run("Bound assertions failed during the run");
    end
  end

endmodule

//--- tb/soc_ctrl_chk.sv
`timescale 1ns/1ps

module soc_ctrl_chk #(
  parameter int unsigned NB_MASTER = 4
) (
  input logic                 HCLK,
  input logic                 HRESETn,
  input logic                 pready_i,
  input logic                 pslverr_i,
  input logic                 soft_reset_i,
  input logic                 rto_i,
  input logic [NB_MASTER-1:0] rto_sticky_i
);

  int unsigned assert_fail_count = 0;  // Failed assertions so far

  // One cycle of pready, then the wait cycle
  a_pready_single: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pready_i |=> !pready_i)
    else begin
      assert_fail_count++;
      $error("pready_o stayed high for two cycles");
    end

  a_pslverr_with_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pslverr_i |-> pready_i)
    else begin
      assert_fail_count++;
      $error("pslverr_o high without pready_o");
    end

  a_soft_reset_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
    soft_reset_i |=> !soft_reset_i)
    else begin
      assert_fail_count++;
      $error("soft_reset_o lasted more than one cycle");
    end

  // Sticky flag is set on the same edge as rto_o
  a_rto_sets_sticky: assert property (@(posedge HCLK) disable iff (!HRESETn)
    rto_i |=> (|rto_sticky_i))
    else begin
      assert_fail_count++;
      $error("rto_o rose without a sticky flag set");
    end

endmodule

//--- source/soc_ctrl_top.sv
`timescale 1ns/1ps

module soc_ctrl_top
  import soc_ctrl_regmap_pkg::*;
  import soc_ctrl_timer_pkg::*;
#(
  parameter int unsigned N_IO          = 64,
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_CLUSTERS   = 1,
  parameter int unsigned NB_MASTER     = 4,
  parameter int unsigned JTAG_REG_SIZE = 8
) (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [11:0]                      paddr_i,
  input  logic [31:0]                      pwdata_i,
  input  logic                             pwrite_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  output logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux_o,
  output logic [31:0]                      fc_bootaddr_o,
  output logic                             fc_fetchen_o,
  input  logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_i,
  output logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_o,
  input  logic                             bootsel_i,
  input  logic                             dmactive_i,
  input  logic                             ref_clk_rising_i,
  input  logic                             stoptimer_i,
  output logic                             wd_expired_o,
  input  logic [NB_MASTER-1:0]             start_rto_i,
  output logic                             rto_o,
  output logic                             soft_reset_o
);

  wd_cmd_t              wd_cmd;
  wd_stat_t             wd_stat;
  rto_cfg_t             rto_cfg;
  logic [NB_MASTER-1:0] rto_expired;
  logic [NB_MASTER-1:0] rto_sticky;

  apb_soc_ctrl #(
    .N_IO          (N_IO),
    .NB_CORES      (NB_CORES),
    .NB_CLUSTERS   (NB_CLUSTERS),
    .NB_MASTER     (NB_MASTER),
    .JTAG_REG_SIZE (JTAG_REG_SIZE)
  ) u_apb_soc_ctrl (
    .HCLK, .HRESETn,
    .paddr_i, .pwdata_i, .pwrite_i, .psel_i, .penable_i,
    .prdata_o, .pready_o, .pslverr_o,
    .pad_cfg_o, .pad_mux_o,
    .fc_bootaddr_o, .fc_fetchen_o,
    .soc_jtag_reg_i, .soc_jtag_reg_o,
    .bootsel_i, .dmactive_i, .soft_reset_o,
    .wd_cmd_o     (wd_cmd),
    .wd_stat_i    (wd_stat),
    .rto_cfg_o    (rto_cfg),
    .rto_sticky_i (rto_sticky)
  );

  soc_watchdog u_soc_watchdog (
    .HCLK, .HRESETn,
    .wd_cmd_i  (wd_cmd),
    .ref_clk_rising_i, .stoptimer_i,
    .wd_stat_o (wd_stat),
    .wd_expired_o
  );

  // One timeout channel per bus master
  for (genvar i = 0; i < NB_MASTER; i++) begin : g_rto
    rto_channel u_rto_channel (
      .HCLK, .HRESETn,
      .reload_i  (rto_cfg.reload),
      .start_i   (start_rto_i[i]),
      .expired_o (rto_expired[i])
    );
  end

  rto_status #(
    .NB_MASTER (NB_MASTER)
  ) u_rto_status (
    .HCLK, .HRESETn,
    .expired_i (rto_expired),
    .clear_i   (rto_cfg.clear),
    .sticky_o  (rto_sticky),
    .rto_o
  );

endmodule

//--- source/apb_soc_ctrl.sv
`timescale 1ns/1ps

module apb_soc_ctrl
  import soc_ctrl_regmap_pkg::*;
  import soc_ctrl_timer_pkg::*;
#(
  parameter int unsigned N_IO          = 64,
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_CLUSTERS   = 1,
  parameter int unsigned NB_MASTER     = 4,
  parameter int unsigned JTAG_REG_SIZE = 8
) (
  input  logic                                 HCLK,
  input  logic                                 HRESETn,
  input  logic [11:0]                          paddr_i,
  input  logic [31:0]                          pwdata_i,
  input  logic                                 pwrite_i,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  output logic [31:0]                          prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o,
  output logic [N_IO-1:0][NBIT_PADCFG-1:0]     pad_cfg_o,
  output logic [N_IO-1:0][NBIT_PADMUX-1:0]     pad_mux_o,
  output logic [31:0]                          fc_bootaddr_o,
  output logic                                 fc_fetchen_o,
  input  logic [JTAG_REG_SIZE-1:0]             soc_jtag_reg_i,
  output logic [JTAG_REG_SIZE-1:0]             soc_jtag_reg_o,
  input  logic                                 bootsel_i,
  input  logic                                 dmactive_i,
  output logic                                 soft_reset_o,
  output wd_cmd_t                              wd_cmd_o,
  input  wd_stat_t                             wd_stat_i,
  output rto_cfg_t                             rto_cfg_o,
  input  logic [NB_MASTER-1:0]                 rto_sticky_i
);

  localparam int unsigned IDX_WIDTH = (N_IO > 1) ? $clog2(N_IO) : 1;

  typedef enum logic [1:0] {FSM_IDLE, FSM_READ, FSM_WRITE, FSM_WAIT} apb_state_e;

  apb_state_e             state;
  pad_word_u              wr_word;
  pad_wcfg_t              rd_wcfg;
  pad_direct_t            rd_direct;
  logic                   is_window;
  logic [7:0]             win_idx;
  logic                   win_in_range;
  logic                   wcfg_in_range;
  logic [31:0]            rd_data;
  logic                   rd_err;
  logic                   wr_err;
  logic [IDX_WIDTH-1:0]   r_io_pad;       // Last selected pad
  logic [JTAG_REG_SIZE-1:0] r_jtag_sync1;
  logic [JTAG_REG_SIZE-1:0] r_jtag_sync2;
  logic [1:0]             r_bootsel;
  logic                   r_boot_captured;

  assign wr_word       = pwdata_i;
  assign is_window     = ({paddr_i[11:10], 10'h000} == PAD_WINDOW_BASE);
  assign win_idx       = paddr_i[9:2];
  assign win_in_range  = (win_idx < N_IO);
  assign wcfg_in_range = (wr_word.wcfg.pad < N_IO);

  // Readback views of the pad registers
  always_comb begin
    rd_wcfg       = '0;
    rd_wcfg.pad   = 8'(r_io_pad);
    rd_wcfg.mux   = pad_mux_o[r_io_pad];
    rd_wcfg.cfg   = pad_cfg_o[r_io_pad];
    rd_direct     = '0;
    if (win_in_range) begin
      rd_direct.mux = pad_mux_o[win_idx[IDX_WIDTH-1:0]];
      rd_direct.cfg = pad_cfg_o[win_idx[IDX_WIDTH-1:0]];
    end
  end

  // Read data and error decode
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    wr_err  = 1'b0;
    if (is_window) begin
      rd_data = win_in_range ? 32'(rd_direct) : BAD_PAD_DATA;
    end else begin
      case (paddr_i)
        REG_INFO: begin
          rd_data = {16'(NB_CORES), 16'(NB_CLUSTERS)};
          wr_err  = 1'b1;                           // Read only
        end
        REG_FCBOOT:         rd_data = fc_bootaddr_o;
        REG_FCFETCH:        rd_data = {31'h0, fc_fetchen_o};
        REG_WCFGFUN,
        REG_RCFGFUN:        rd_data = 32'(rd_wcfg);
        REG_JTAGREG: begin
          rd_data[JTAG_REG_SIZE-1:0]   = soc_jtag_reg_o;
          rd_data[8 +: JTAG_REG_SIZE]  = r_jtag_sync2;
        end
        REG_BOOTSEL: begin
          rd_data = {dmactive_i, bootsel_i, 28'h0, r_bootsel};
          wr_err  = 1'b1;                           // Read only
        end
        REG_WD_COUNT:       rd_data = {1'b0, wd_stat_i.count};
        REG_WD_CONTROL:     rd_data = {wd_stat_i.enabled, wd_stat_i.count};
        REG_RTO_PERIPHERAL: rd_data = 32'(rto_sticky_i);
        REG_RTO_COUNT:      rd_data = {12'h0, rto_cfg_o.reload};
        REG_SOFT_RESET:     rd_data = '0;
        default: begin
          rd_data = BAD_ADDR_DATA;
          rd_err  = 1'b1;
          wr_err  = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state          <= FSM_IDLE;
      pready_o       <= 1'b0;
      pslverr_o      <= 1'b0;
      prdata_o       <= '0;
      fc_bootaddr_o  <= BOOTADDR_RESET;
      fc_fetchen_o   <= 1'b1;                       // FC runs out of reset
      soc_jtag_reg_o <= '0;
      r_io_pad       <= '0;
      pad_cfg_o      <= '1;
      pad_mux_o      <= '0;
      wd_cmd_o       <= WD_CMD_IDLE;
      rto_cfg_o      <= '{reload: RTO_RELOAD_RESET, clear: 1'b0};
      soft_reset_o   <= 1'b0;
    end else begin
      wd_cmd_o.count_load <= 1'b0;                  // Strobes drop after one cycle
      wd_cmd_o.start      <= 1'b0;
      wd_cmd_o.kick       <= 1'b0;
      rto_cfg_o.clear     <= 1'b0;
      soft_reset_o        <= 1'b0;
      case (state)
        FSM_IDLE: begin
          if (psel_i && penable_i) begin
            state <= pwrite_i ? FSM_WRITE : FSM_READ;
          end
        end
        FSM_WRITE: begin
          pready_o  <= 1'b1;
          pslverr_o <= wr_err;
          state     <= FSM_WAIT;
          if (is_window) begin
            if (win_in_range) begin
              r_io_pad                            <= win_idx[IDX_WIDTH-1:0];
              pad_cfg_o[win_idx[IDX_WIDTH-1:0]]   <= wr_word.direct.cfg;
              pad_mux_o[win_idx[IDX_WIDTH-1:0]]   <= wr_word.direct.mux;
            end
          end else begin
            case (paddr_i)
              REG_FCBOOT:  fc_bootaddr_o  <= pwdata_i;
              REG_FCFETCH: fc_fetchen_o   <= pwdata_i[0];
              REG_WCFGFUN: begin
                if (wcfg_in_range) begin
                  r_io_pad                                    <= wr_word.wcfg.pad[IDX_WIDTH-1:0];
                  pad_cfg_o[wr_word.wcfg.pad[IDX_WIDTH-1:0]]  <= wr_word.wcfg.cfg;
                  pad_mux_o[wr_word.wcfg.pad[IDX_WIDTH-1:0]]  <= wr_word.wcfg.mux;
                end
              end
              REG_RCFGFUN: begin
                if (wcfg_in_range) r_io_pad <= wr_word.wcfg.pad[IDX_WIDTH-1:0];
              end
              REG_JTAGREG: soc_jtag_reg_o <= pwdata_i[JTAG_REG_SIZE-1:0];
              REG_WD_COUNT: begin
                wd_cmd_o.count_load <= 1'b1;
                wd_cmd_o.count      <= pwdata_i[30:0];
              end
              REG_WD_CONTROL: begin
                wd_cmd_o.start <= pwdata_i[31];
                wd_cmd_o.kick  <= (pwdata_i[15:0] == WD_KICK_KEY);
              end
              REG_RTO_PERIPHERAL: rto_cfg_o.clear  <= 1'b1;
              REG_RTO_COUNT:      rto_cfg_o.reload <= {pwdata_i[19:4], 4'hF};
              REG_SOFT_RESET: begin
                soft_reset_o     <= 1'b1;
                r_io_pad         <= '0;
                pad_cfg_o        <= '1;
                pad_mux_o        <= '0;
                rto_cfg_o.reload <= RTO_RELOAD_RESET;
                rto_cfg_o.clear  <= 1'b1;
              end
              default: ;
            endcase
          end
        end
        FSM_READ: begin
          pready_o  <= 1'b1;
          pslverr_o <= rd_err;
          prdata_o  <= rd_data;
          state     <= FSM_WAIT;
          if (is_window && win_in_range) r_io_pad <= win_idx[IDX_WIDTH-1:0];
        end
        FSM_WAIT: begin
          pready_o  <= 1'b0;                        // One idle cycle before next sample
          pslverr_o <= 1'b0;
          state     <= FSM_IDLE;
        end
        default: state <= FSM_IDLE;
      endcase
    end
  end

  // JTAG input synchronizer and boot pin capture on reset release
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      r_jtag_sync1    <= '0;
      r_jtag_sync2    <= '0;
      r_bootsel       <= '0;
      r_boot_captured <= 1'b0;
    end else begin
      r_jtag_sync1 <= soc_jtag_reg_i;
      r_jtag_sync2 <= r_jtag_sync1;
      if (!r_boot_captured) begin
        r_bootsel       <= {dmactive_i, bootsel_i};
        r_boot_captured <= 1'b1;
      end
    end
  end

endmodule

//--- source/soc_watchdog.sv
`timescale 1ns/1ps

module soc_watchdog
  import soc_ctrl_timer_pkg::*;
(
  input  logic     HCLK,
  input  logic     HRESETn,
  input  wd_cmd_t  wd_cmd_i,
  input  logic     ref_clk_rising_i,
  input  logic     stoptimer_i,
  output wd_stat_t wd_stat_o,
  output logic     wd_expired_o
);

  localparam logic [30:0] WD_LOAD_RESET = 31'd32768;

  logic [30:0] r_load;     // Reload value
  logic [30:0] r_count;    // Current count
  logic        r_enabled;
  logic        count_tick;

  // Count only on reference ticks while running and not halted
  assign count_tick = r_enabled && !stoptimer_i && ref_clk_rising_i && (r_count != '0);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      r_load       <= WD_LOAD_RESET;
      r_count      <= WD_LOAD_RESET;
      r_enabled    <= 1'b0;                         // Disabled on power up
      wd_expired_o <= 1'b0;
    end else begin
      wd_expired_o <= (r_count == '0);

      // Load value is frozen once the watchdog runs
      if (wd_cmd_i.count_load && !r_enabled) begin
        r_load <= wd_cmd_i.count;
      end

      if (wd_cmd_i.start) begin
        r_enabled <= 1'b1;
        r_count   <= r_load;
      end else if (wd_cmd_i.kick && r_enabled) begin
        r_count <= r_load;
      end else if (count_tick) begin
        r_count <= r_count - 31'd1;                 // Holds at zero until kicked
      end
    end
  end

  assign wd_stat_o.enabled = r_enabled;
  assign wd_stat_o.count   = r_count;

endmodule

//--- source/rto_status.sv
`timescale 1ns/1ps

module rto_status #(
  parameter int unsigned NB_MASTER = 4
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic [NB_MASTER-1:0] expired_i,
  input  logic                 clear_i,
  output logic [NB_MASTER-1:0] sticky_o,
  output logic                 rto_o
);

  logic [NB_MASTER-1:0] sticky_base;
  logic                 any_expired;

  // Clear first so a live expiry still sets its flag
  assign sticky_base = clear_i ? '0 : sticky_o;
  assign any_expired = |expired_i;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sticky_o <= '0;
      rto_o    <= 1'b0;
    end else begin
      sticky_o <= sticky_base | expired_i;   // One flag per master
      rto_o    <= any_expired;
    end
  end

endmodule

//--- source/rto_channel.sv
`timescale 1ns/1ps

module rto_channel (
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic [19:0] reload_i,
  input  logic        start_i,
  output logic        expired_o
);

  logic [19:0] r_count;
  logic        count_zero;

  assign count_zero = (r_count == '0);

  // Reload while idle, count down while the master waits for ready
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      r_count <= '1;
    end else begin
      if (!start_i) begin
        r_count <= reload_i;
      end else if (!count_zero) begin
        r_count <= r_count - 20'd1;
      end
    end
  end

  // Timeout only counts while the access is still pending
  assign expired_o = count_zero && start_i;

endmodule

//--- source/soc_ctrl_timer_pkg.sv
package soc_ctrl_timer_pkg;

  // Watchdog commands from the register block, strobes last one cycle
  typedef struct packed {
    logic        count_load;  // Load a new reload value
    logic        start;       // Enable and copy the load value
    logic        kick;        // Reload, key already checked
    logic [30:0] count;       // Value for count_load
  } wd_cmd_t;

  // Watchdog state for readback
  typedef struct packed {
    logic        enabled;
    logic [30:0] count;       // Current count
  } wd_stat_t;

  // Ready-timeout setup shared by all channels
  typedef struct packed {
    logic [19:0] reload;      // Countdown start value
    logic        clear;       // Clears the sticky flags
  } rto_cfg_t;

  // Idle command for the register block
  localparam wd_cmd_t WD_CMD_IDLE = '{
    count_load: 1'b0,
    start:      1'b0,
    kick:       1'b0,
    count:      31'd0
  };

endpackage

//--- source/soc_ctrl_regmap_pkg.sv
package soc_ctrl_regmap_pkg;

  // APB register offsets
  localparam logic [11:0] REG_INFO           = 12'h000;  // Cores and clusters
  localparam logic [11:0] REG_FCBOOT         = 12'h004;  // FC boot address
  localparam logic [11:0] REG_FCFETCH        = 12'h008;  // FC fetch enable
  localparam logic [11:0] REG_WCFGFUN        = 12'h060;  // Indirect pad write
  localparam logic [11:0] REG_RCFGFUN        = 12'h064;  // Indirect pad select and read
  localparam logic [11:0] REG_JTAGREG        = 12'h074;
  localparam logic [11:0] REG_BOOTSEL        = 12'h0C4;
  localparam logic [11:0] REG_WD_COUNT       = 12'h0D0;
  localparam logic [11:0] REG_WD_CONTROL     = 12'h0D4;
  localparam logic [11:0] REG_RTO_PERIPHERAL = 12'h0E0;  // Sticky timeout flags
  localparam logic [11:0] REG_RTO_COUNT      = 12'h0E4;  // Timeout reload
  localparam logic [11:0] REG_SOFT_RESET     = 12'h0FC;

  // One word per pad from here on, 0x400 + 4 * index
  localparam logic [11:0] PAD_WINDOW_BASE = 12'h400;

  localparam int unsigned NBIT_PADCFG = 6;
  localparam int unsigned NBIT_PADMUX = 2;

  localparam logic [15:0] WD_KICK_KEY      = 16'h6699;
  localparam logic [31:0] BOOTADDR_RESET   = 32'h1A00_0080;
  localparam logic [19:0] RTO_RELOAD_RESET = 20'h000FF;

  localparam logic [31:0] BAD_ADDR_DATA = 32'hDEAD_BEEF;  // Unmapped address
  localparam logic [31:0] BAD_PAD_DATA  = 32'h0095_BEEF;  // Pad index beyond N_IO

  // Indirect format used by REG_WCFGFUN and REG_RCFGFUN
  typedef struct packed {
    logic [7-NBIT_PADCFG:0]  rsvd_hi;
    logic [NBIT_PADCFG-1:0]  cfg;      // Bits 29:24
    logic [7-NBIT_PADMUX:0]  rsvd_mid;
    logic [NBIT_PADMUX-1:0]  mux;      // Bits 17:16
    logic [7:0]              rsvd_lo;
    logic [7:0]              pad;      // Pad index
  } pad_wcfg_t;

  // Direct format of the pad window, one pad per word
  typedef struct packed {
    logic [17:0]             rsvd_hi;
    logic [NBIT_PADCFG-1:0]  cfg;      // Bits 13:8
    logic [7-NBIT_PADMUX:0]  rsvd_lo;
    logic [NBIT_PADMUX-1:0]  mux;      // Bits 1:0
  } pad_direct_t;

  // Same write word, decoded by address
  typedef union packed {
    pad_wcfg_t   wcfg;
    pad_direct_t direct;
  } pad_word_u;

endpackage
